// File: all.f
hdl/br_pkg.sv
hdl/branch_eval.sv
hdl/fu_br.sv
hdl/bht_update_arb.sv
hdl/bht.sv
hdl/br_unit_top.sv
dv/br_unit_tb.sv

// File: dv/br_unit_tb.sv
`timescale 1ns/1ns

module br_unit_tb;
    import br_pkg::*;

    localparam int IDX_W   = 6;
    localparam int ENTRIES = 1 << IDX_W;

    logic         clk;
    logic         rst_n;
    br_lane_t     lane_a;
    br_lane_t     lane_b;
    logic         stall_dcache_buf;
    logic [31:0]  fetch_pc;
    br_redirect_t redirect;
    logic         pred_taken;

    logic [31:0]  lfsr_q;                       // Stimulus LFSR state
    logic [1:0]   ref_cnt [ENTRIES];            // Model counters
    logic [1:0]   snap_cnt [ENTRIES];           // Copy taken before a stall
    logic         ref_pend_v;                   // Model pending slot
    logic [31:0]  ref_pend_pc;
    logic         ref_pend_t;
    int           checks;
    int           errors;

    br_unit_top #(.BHT_IDX_W(IDX_W)) dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane_a           (lane_a),
        .lane_b           (lane_b),
        .stall_dcache_buf (stall_dcache_buf),
        .fetch_pc         (fetch_pc),
        .redirect         (redirect),
        .pred_taken       (pred_taken)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    // Taps 32,22,2,1
    function automatic logic next_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [IDX_W-1:0] idx_of(input logic [31:0] pc);
        return pc[IDX_W+1:2];
    endfunction

    // Direction and target straight from the branch type rules
    function automatic br_result_t ref_eval(input br_lane_t l);
        br_result_t r;
        logic       lt_s;
        logic       lt_u;
        lt_u = l.rdata1 < l.rdata2;
        lt_s = (l.rdata1 ^ 32'h8000_0000) < (l.rdata2 ^ 32'h8000_0000); // Bias to unsigned
        r.target = (l.br_type == BR_JIRL) ? l.rdata1 + l.imm : l.pc + l.imm;
        case (l.br_type)
            BR_BEQ:               r.taken = (l.rdata1 == l.rdata2);
            BR_BNE:               r.taken = (l.rdata1 != l.rdata2);
            BR_BLT:               r.taken = lt_s;
            BR_BGE:               r.taken = !lt_s;
            BR_BLTU:              r.taken = lt_u;
            BR_BGEU:              r.taken = !lt_u;
            BR_B, BR_BL, BR_JIRL: r.taken = 1'b1;
            default:              r.taken = 1'b0;
        endcase
        return r;
    endfunction

    function automatic br_lane_t rand_lane(input logic branch_only);
        br_lane_t   l;
        logic [3:0] t;
        l.pc     = 32'h4000 + (rand_bits(4) << 2); // 16 PCs, indices collide
        l.rdata1 = rand_bits(32);
        l.rdata2 = next_bit() ? l.rdata1 : rand_bits(32); // Equal half the time
        l.imm    = rand_bits(12) << 2;
        if (l.imm[13]) begin
            l.imm = l.imm | 32'hFFFF_C000;      // Sign extend
        end
        t = 4'(rand_bits(4));
        if (t > 4'd9) begin
            t = t - 4'd6;
        end
        if (branch_only && t == 4'd0) begin
            t = 4'd1;
        end
        l.br_type    = br_type_e'(t);
        l.pred_taken = next_bit();
        return l;
    endfunction

    function automatic br_lane_t make_lane(input logic [31:0] pc, input br_type_e t,
                                           input logic [31:0] r1, input logic pred);
        br_lane_t l;
        l            = '0;
        l.pc         = pc;
        l.br_type    = t;
        l.rdata1     = r1;
        l.rdata2     = 32'd1;
        l.imm        = 32'h40;
        l.pred_taken = pred;
        return l;
    endfunction

    task automatic train_model(input logic [31:0] pc, input logic taken);
        logic [IDX_W-1:0] i;
        i = idx_of(pc);
        if (taken && ref_cnt[i] != 2'd3) begin
            ref_cnt[i] = ref_cnt[i] + 2'd1;
        end else if (!taken && ref_cnt[i] != 2'd0) begin
            ref_cnt[i] = ref_cnt[i] - 2'd1;
        end
    endtask

    // One cycle: drive, check at negedge, then advance the model to the next edge
    task automatic step(input br_lane_t a, input br_lane_t b, input logic stall,
                        input logic [31:0] fpc);
        br_result_t  ra;
        br_result_t  rb;
        logic        mis_a;
        logic        mis_b;
        logic        exp_valid;
        logic [31:0] exp_pc;
        logic        cv [3];
        logic [31:0] cpc [3];
        logic        ct [3];
        int          n;
        @(posedge clk);
        lane_a           <= a;
        lane_b           <= b;
        stall_dcache_buf <= stall;
        fetch_pc         <= fpc;
        @(negedge clk);
        ra        = ref_eval(a);
        rb        = ref_eval(b);
        mis_a     = (a.br_type != BR_NONE) && (a.pred_taken != ra.taken);
        mis_b     = (b.br_type != BR_NONE) && (b.pred_taken != rb.taken);
        exp_valid = (mis_a || mis_b) && !stall;
        if (mis_a) begin
            exp_pc = ra.taken ? ra.target : a.pc + 32'd4;
        end else begin
            exp_pc = rb.taken ? rb.target : b.pc + 32'd4;
        end
        checks += 2;
        assert (redirect.valid == exp_valid) else begin
            $display("error redirect.valid exp %h got %h", exp_valid, redirect.valid);
            errors++;
        end
        if (exp_valid) begin
            checks += 2;
            assert (redirect.from_a == mis_a) else begin
                $display("error redirect.from_a exp %h got %h", mis_a, redirect.from_a);
                errors++;
            end
            assert (redirect.pc == exp_pc) else begin
                $display("error redirect.pc exp %h got %h", exp_pc, redirect.pc);
                errors++;
            end
        end
        assert (pred_taken == ref_cnt[idx_of(fpc)][1]) else begin
            $display("error pred_taken pc %h exp %h got %h", fpc,
                     ref_cnt[idx_of(fpc)][1], pred_taken);
            errors++;
        end
        cv[0]  = ref_pend_v;                    // Pending goes first
        cpc[0] = ref_pend_pc;
        ct[0]  = ref_pend_t;
        cv[1]  = (a.br_type != BR_NONE) && !stall;
        cpc[1] = a.pc;
        ct[1]  = ra.taken;
        cv[2]  = (b.br_type != BR_NONE) && !stall && !mis_a; // Wrong path behind A
        cpc[2] = b.pc;
        ct[2]  = rb.taken;
        n          = 0;
        ref_pend_v = 1'b0;
        for (int k = 0; k < 3; k++) begin
            if (cv[k]) begin
                if (n == 0) begin
                    train_model(cpc[k], ct[k]);
                end else if (n == 1) begin
                    ref_pend_v  = 1'b1;         // Slot refill
                    ref_pend_pc = cpc[k];
                    ref_pend_t  = ct[k];
                end
                n++;                            // Third one dropped
            end
        end
    endtask

    task automatic expect_pred(input logic exp, input string what);
        checks++;
        assert (pred_taken == exp) else begin
            $display("error pred_taken (%s) exp %h got %h", what, exp, pred_taken);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int e0, input int c0);
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    task automatic wait_reset(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < 20 && !ok; n++) begin // Release timeout
            @(posedge clk);
            ok = rst_n;
        end
    endtask

    initial begin
        br_lane_t    idle;
        br_lane_t    a;
        br_lane_t    b;
        br_result_t  res;
        logic [31:0] pc;
        logic        ok;
        int          e0;
        int          c0;
        lfsr_q           = 32'd79269;
        lane_a           = '0;
        lane_b           = '0;
        stall_dcache_buf = 1'b0;
        fetch_pc         = '0;
        idle             = '0;
        checks           = 0;
        errors           = 0;
        ref_pend_v       = 1'b0;
        ref_pend_pc      = '0;
        ref_pend_t       = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            ref_cnt[i] = 2'd1;                  // Weakly not taken
        end
        wait_reset(ok);
        if (!ok) begin
            $display("reset never released");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            e0 = errors;
            c0 = checks;
            for (int i = 0; i < 300; i++) begin
                step(rand_lane(1'b0), idle, 1'b0, 32'h4000 + (rand_bits(4) << 2));
            end
            report_test("branch evaluation", e0, c0);

            e0 = errors;
            c0 = checks;
            for (int i = 0; i < 100; i++) begin
                a = rand_lane(1'b1);
                b = rand_lane(1'b1);
                res = ref_eval(a);
                a.pred_taken = (i < 50) ? !res.taken : res.taken;
                res = ref_eval(b);
                b.pred_taken = !res.taken;
                step(a, b, 1'b0, b.pc);
            end
            report_test("dual-lane priority", e0, c0);

            e0 = errors;
            c0 = checks;
            step(idle, idle, 1'b0, 32'h4000);   // Drain pending slot
            step(idle, idle, 1'b0, 32'h4000);
            snap_cnt = ref_cnt;
            for (int i = 0; i < 40; i++) begin
                pc = 32'h4000 + (rand_bits(4) << 2);
                step(rand_lane(1'b1), rand_lane(1'b1), 1'b1, pc);
                expect_pred(snap_cnt[idx_of(pc)][1], "stalled");
            end
            report_test("stall gating", e0, c0);

            e0 = errors;
            c0 = checks;
            pc = 32'h40F0;                      // Index 60, unused elsewhere
            for (int i = 0; i < 6; i++) begin
                step(make_lane(pc, BR_B, 32'd0, 1'b0), idle, 1'b0, pc);
            end
            expect_pred(1'b1, "after taken run");
            for (int i = 0; i < 6; i++) begin
                step(make_lane(pc, BR_BEQ, 32'd0, 1'b0), idle, 1'b0, pc);
            end
            expect_pred(1'b0, "after not-taken run");
            report_test("training and saturation", e0, c0);

            e0 = errors;
            c0 = checks;
            for (int i = 0; i < 400; i++) begin
                a = rand_lane(next_bit() | next_bit());
                b = rand_lane(next_bit() | next_bit());
                step(a, b, rand_bits(3) == 0, 32'h4000 + (rand_bits(4) << 2));
            end
            pc = 32'h40E0;                      // Lane B PC, index 56
            for (int i = 0; i < 4; i++) begin
                step(make_lane(pc, BR_BEQ, 32'd0, 1'b0), idle, 1'b0, pc);
            end
            for (int i = 0; i < 5; i++) begin
                step(make_lane(32'h40D0, BR_B, 32'd0, 1'b0),
                     make_lane(pc, BR_B, 32'd0, 1'b1), 1'b0, pc);
                expect_pred(1'b0, "squashed lane B");
            end
            report_test("arbitration and dropping", e0, c0);

            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// File: hdl/br_unit_top.sv
`timescale 1ns/1ns

module br_unit_top #(
    parameter int BHT_IDX_W = br_pkg::BHT_IDX_W_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  br_pkg::br_lane_t     lane_a,        // Older EX lane
    input  br_pkg::br_lane_t     lane_b,        // Younger EX lane
    input  logic                 stall_dcache_buf,
    input  logic [31:0]          fetch_pc,      // Fetch lookup address
    output br_pkg::br_redirect_t redirect,      // Mispredict redirect
    output logic                 pred_taken     // Fetch prediction
);
    import br_pkg::*;

    br_result_t res_a;                          // Lane A actual outcome
    br_result_t res_b;                          // Lane B actual outcome
    bht_upd_t   upd_a;
    bht_upd_t   upd_b;
    bht_upd_t   bht_wr;                         // Arbitrated write

    branch_eval eval_a_i (
        .lane   (lane_a),
        .result (res_a)
    );

    branch_eval eval_b_i (
        .lane   (lane_b),
        .result (res_b)
    );

    fu_br fu_br_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane_a           (lane_a),
        .lane_b           (lane_b),
        .res_a            (res_a),
        .res_b            (res_b),
        .stall_dcache_buf (stall_dcache_buf),
        .redirect         (redirect),
        .upd_a            (upd_a),
        .upd_b            (upd_b)
    );

    bht_update_arb arb_i (
        .clk   (clk),
        .rst_n (rst_n),
        .upd_a (upd_a),
        .upd_b (upd_b),
        .wr    (bht_wr)
    );

    bht #(
        .BHT_IDX_W (BHT_IDX_W)
    ) bht_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (bht_wr),
        .fetch_pc   (fetch_pc),
        .pred_taken (pred_taken)
    );

endmodule

// File: hdl/bht.sv
`timescale 1ns/1ns

module bht #(
    parameter int BHT_IDX_W = br_pkg::BHT_IDX_W_DEF
) (
    input  logic             clk,
    input  logic             rst_n,
    input  br_pkg::bht_upd_t wr,                // Training write
    input  logic [31:0]      fetch_pc,          // Prediction lookup
    output logic             pred_taken         // Counter MSB
);
    localparam int ENTRIES = 1 << BHT_IDX_W;

    logic [1:0]           cnt_q [ENTRIES];      // 2-bit saturating counters
    logic [BHT_IDX_W-1:0] wr_idx;
    logic [BHT_IDX_W-1:0] rd_idx;
    logic [1:0]           cnt_cur;              // Counter under write
    logic [1:0]           cnt_nxt;

    // Word-aligned PCs, drop the low two bits
    assign wr_idx = wr.pc[BHT_IDX_W+1:2];
    assign rd_idx = fetch_pc[BHT_IDX_W+1:2];

    assign cnt_cur = cnt_q[wr_idx];

    always_comb begin
        cnt_nxt = cnt_cur;
        if (wr.taken) begin
            if (cnt_cur != 2'b11) begin
                cnt_nxt = cnt_cur + 2'd1;       // Toward strongly taken
            end
        end else begin
            if (cnt_cur != 2'b00) begin
                cnt_nxt = cnt_cur - 2'd1;       // Toward strongly not taken
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                cnt_q[i] <= 2'b01;              // Weakly not taken
            end
        end else if (wr.valid) begin
            cnt_q[wr_idx] <= cnt_nxt;
        end
    end

    // Read port sees writes from the next cycle on
    assign pred_taken = cnt_q[rd_idx][1];

endmodule

// File: hdl/bht_update_arb.sv
`timescale 1ns/1ns

module bht_update_arb (
    input  logic             clk,
    input  logic             rst_n,
    input  br_pkg::bht_upd_t upd_a,             // Older lane request
    input  br_pkg::bht_upd_t upd_b,             // Younger lane request
    output br_pkg::bht_upd_t wr                 // Single table write port
);
    import br_pkg::*;

    logic        pend_vld_q;                    // Slot occupied
    logic [31:0] pend_pc_q;                     // Slot payload
    logic        pend_taken_q;
    bht_upd_t    pend;                          // Slot as a request
    bht_upd_t    pend_d;                        // Next slot contents

    assign pend.valid = pend_vld_q;
    assign pend.pc    = pend_pc_q;
    assign pend.taken = pend_taken_q;

    // Order is pending, A, B; first wins the port, second takes the slot
    always_comb begin
        wr     = '0;
        pend_d = '0;
        if (pend_vld_q) begin
            wr = pend;
            if (upd_a.valid) begin
                pend_d = upd_a;                 // B dropped if also valid
            end else if (upd_b.valid) begin
                pend_d = upd_b;
            end
        end else if (upd_a.valid) begin
            wr = upd_a;
            if (upd_b.valid) begin
                pend_d = upd_b;
            end
        end else if (upd_b.valid) begin
            wr = upd_b;
        end
    end

    // Slot always drains when full, so it refills or clears each edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_vld_q <= 1'b0;
        end else begin
            pend_vld_q <= pend_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_d.valid) begin
            pend_pc_q    <= pend_d.pc;
            pend_taken_q <= pend_d.taken;
        end
    end

    // Pending entry must never be bypassed by a newer lane
    a_pend_first : assert property (
        @(posedge clk) disable iff (!rst_n)
        pend_d.valid |=> (wr == $past(pend_d))
    ) else $error("bht_update_arb: write port skipped pending entry");

endmodule

// File: hdl/fu_br.sv
`timescale 1ns/1ns

module fu_br (
    input  logic                 clk,
    input  logic                 rst_n,
    input  br_pkg::br_lane_t     lane_a,        // Older lane
    input  br_pkg::br_lane_t     lane_b,        // Younger lane
    input  br_pkg::br_result_t   res_a,         // Lane A evaluation
    input  br_pkg::br_result_t   res_b,         // Lane B evaluation
    input  logic                 stall_dcache_buf,
    output br_pkg::br_redirect_t redirect,      // Fetch redirect
    output br_pkg::bht_upd_t     upd_a,         // Lane A training
    output br_pkg::bht_upd_t     upd_b          // Lane B training
);
    import br_pkg::*;

    logic        is_br_a;                       // Lane A holds a branch
    logic        is_br_b;                       // Lane B holds a branch
    logic        mis_a;                         // Lane A mispredicted
    logic        mis_b;                         // Lane B mispredicted
    logic [31:0] fix_pc_a;                      // Lane A correct next PC
    logic [31:0] fix_pc_b;                      // Lane B correct next PC

    assign is_br_a = (lane_a.br_type != BR_NONE);
    assign is_br_b = (lane_b.br_type != BR_NONE);

    // Prediction disagrees with actual direction
    assign mis_a = is_br_a & (lane_a.pred_taken ^ res_a.taken);
    assign mis_b = is_br_b & (lane_b.pred_taken ^ res_b.taken);

    // Taken goes to target, not taken falls through
    assign fix_pc_a = res_a.taken ? res_a.target : (lane_a.pc + 32'd4);
    assign fix_pc_b = res_b.taken ? res_b.target : (lane_b.pc + 32'd4);

    // Stalled cycles replay the same EX contents, fire only once
    assign redirect.valid  = (mis_a | mis_b) & ~stall_dcache_buf;
    assign redirect.from_a = mis_a;             // A has priority
    assign redirect.pc     = mis_a ? fix_pc_a : fix_pc_b;

    assign upd_a.valid = is_br_a & ~stall_dcache_buf;
    assign upd_a.pc    = lane_a.pc;
    assign upd_a.taken = res_a.taken;

    // B is on the wrong path after an A mispredict
    assign upd_b.valid = is_br_b & ~stall_dcache_buf & ~mis_a;
    assign upd_b.pc    = lane_b.pc;
    assign upd_b.taken = res_b.taken;

    // A redirect needs a real branch in some lane
    a_redirect_has_branch : assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.valid |-> (lane_a.br_type != BR_NONE) || (lane_b.br_type != BR_NONE)
    ) else $error("fu_br: redirect without a branch in either lane");

endmodule

// File: hdl/branch_eval.sv
`timescale 1ns/1ns

module branch_eval (
    input  br_pkg::br_lane_t   lane,            // Lane to evaluate
    output br_pkg::br_result_t result           // Actual direction and target
);
    import br_pkg::*;

    logic        eq;                            // Operands equal
    logic        lt_s;                          // Signed less than
    logic        lt_u;                          // Unsigned less than
    logic [31:0] base;                          // Target base address

    assign eq   = (lane.rdata1 == lane.rdata2);
    assign lt_s = ($signed(lane.rdata1) < $signed(lane.rdata2));
    assign lt_u = (lane.rdata1 < lane.rdata2);

    // JIRL jumps off rj, everything else is pc relative
    assign base = (lane.br_type == BR_JIRL) ? lane.rdata1 : lane.pc;

    assign result.target = base + lane.imm;

    always_comb begin
        case (lane.br_type)
            BR_BEQ: begin
                result.taken = eq;
            end
            BR_BNE: begin
                result.taken = ~eq;
            end
            BR_BLT: begin
                result.taken = lt_s;
            end
            BR_BGE: begin
                result.taken = ~lt_s;
            end
            BR_BLTU: begin
                result.taken = lt_u;
            end
            BR_BGEU: begin
                result.taken = ~lt_u;
            end
            BR_B, BR_BL, BR_JIRL: begin
                result.taken = 1'b1;            // Unconditional
            end
            default: begin
                result.taken = 1'b0;            // BR_NONE and unused codes
            end
        endcase
    end

endmodule

// File: hdl/br_pkg.sv
package br_pkg;

    // Default BHT index width, 64 counters
    localparam int BHT_IDX_W_DEF = 6;

    // Branch types as decoded upstream
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,                         // Not a branch
        BR_BEQ  = 4'd1,                         // rj == rk
        BR_BNE  = 4'd2,                         // rj != rk
        BR_BLT  = 4'd3,                         // Signed less than
        BR_BGE  = 4'd4,                         // Signed greater or equal
        BR_BLTU = 4'd5,                         // Unsigned less than
        BR_BGEU = 4'd6,                         // Unsigned greater or equal
        BR_B    = 4'd7,                         // Unconditional, pc relative
        BR_BL   = 4'd8,                         // Call, pc relative
        BR_JIRL = 4'd9                          // Register indirect jump
    } br_type_e;

    // One execute-stage lane
    typedef struct packed {
        logic [31:0] pc;                        // Branch PC
        logic [31:0] rdata1;                    // First register operand
        logic [31:0] rdata2;                    // Second register operand
        logic [31:0] imm;                       // Sign-extended offset
        br_type_e    br_type;                   // Decoded branch type
        logic        pred_taken;                // Fetch-time prediction
    } br_lane_t;

    // Evaluator output
    typedef struct packed {
        logic        taken;                     // Actual direction
        logic [31:0] target;                    // Taken target
    } br_result_t;

    // Fetch redirect on mispredict
    typedef struct packed {
        logic        valid;                     // Redirect needed this cycle
        logic        from_a;                    // Lane A mispredicted
        logic [31:0] pc;                        // Correct next PC
    } br_redirect_t;

    // BHT training request
    typedef struct packed {
        logic        valid;                     // Request present
        logic [31:0] pc;                        // Branch PC, indexes the table
        logic        taken;                     // Actual direction
    } bht_upd_t;

endpackage
